// ==== Makefile ====
# Verilator build and run for the UBA pager testbench
VERILATOR ?= verilator
TOP       ?= ubaPagerTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
SOURCES   := $(wildcard verilog/*.sv dv/*.sv)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@test -f $(LOG) || (echo "No log file $(LOG), run the simulation first"; exit 1)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "No pass message found in $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
verilog/ubaPagePkg.sv
verilog/pageRam.sv
verilog/pageRegAccess.sv
verilog/pageTranslate.sv
verilog/ubaPager.sv
dv/ubaPagerChecker.sv
dv/ubaPagerTb.sv

// ==== dv/ubaPagerChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ubaPagerChecker
   import ubaPagePkg::*;
#(
   parameter int memCredits = 2
)
(
   input logic                clk,
   input logic                rstN,
   input logic                regWrite,
   input logic                regRead,
   input logic [0:vpnWidth-1] regIndex,
   input logic [0:busWidth-1] regData,
   input logic                regRdValid,
   input logic [0:busWidth-1] regRdData,
   input logic                devValid,
   input logic [0:busWidth-1] devAddr,
   input logic                devCredit,
   input logic                memValid,
   input logic [0:busWidth-1] memAddr,
   input logic                memFail,
   input logic                memCreditIn
);

   // Shadow of the page table with flags 0..3 then the PPN
   logic [0:entryWidth-1] shadow [0:(1 << vpnWidth)-1];
   // Expected memory words in request order with the fail flag in the last bit
   logic [0:busWidth]     expQ [$];
   logic [0:busWidth-1]   readExp;
   logic                  readPending;
   int                    memCreditModel;
   string                 testName = "idle";
   int                    testChecks = 0;
   int                    testErrors = 0;
   int                    testReqs = 0;
   int                    testCredits = 0;
   int                    testsRun = 0;
   int                    totalChecks = 0;
   int                    totalErrors = 0;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Write layout has flags at RH 18..21 and the PPN at 25..35
   function automatic logic [0:entryWidth-1] packEntry(input logic [0:busWidth-1] data);
      logic [0:entryWidth-1] e;
      e = '0;
      e[flagRpw:flagVld] = data[18:21];
      e[numFlags:entryWidth-1] = data[25:35];
      return e;
   endfunction

   // Read layout has flags at 5..8 and the PPN at 16..26 with the rest zero
   function automatic logic [0:busWidth-1] refReadData(input logic [0:entryWidth-1] e);
      logic [0:busWidth-1] d;
      d = '0;
      d[5:8] = e[flagRpw:flagVld];
      d[16:26] = e[numFlags:entryWidth-1];
      return d;
   endfunction

   // Address is the high 16 bits then the PPN then the word number
   // Fail flag rides in the extra bit
   function automatic logic [0:busWidth] refTranslate(input logic [0:busWidth-1] addr,
                                                      input logic [0:entryWidth-1] e);
      logic [0:busWidth-1] m;
      logic                fail;
      m = {addr[0:15], e[numFlags:entryWidth-1], addr[25:33]};
      fail = addr[18] | ~e[flagVld] | (e[flagFtm] & (addr[34] | addr[35]));
      return {m, fail};
   endfunction

   ////////////////////////////////////////
   // Reporting
   ////////////////////////////////////////

   task automatic mismatch(input string what, input logic [0:busWidth-1] expVal,
                           input logic [0:busWidth-1] actVal);
      $display("[ERROR] %s: %s expected %h actual %h", testName, what, expVal, actVal);
      testErrors++;
   endtask

   task automatic reportFailure(input string msg);
      $display("Failure in %s: %s", testName, msg);
      testErrors++;
   endtask

   task automatic beginTest(input string name);
      testName = name;
      testChecks = 0;
      testErrors = 0;
      testReqs = 0;
      testCredits = 0;
   endtask

   task automatic endTest();
      if (testCredits != testReqs)
         reportFailure($sformatf("%0d requests sent but %0d devCredit pulses seen",
                                 testReqs, testCredits));
      if (expQ.size() != 0)
         reportFailure($sformatf("%0d requests never came out on memValid", expQ.size()));
      $display("Test %s finished: %0d checks, %0d errors", testName, testChecks, testErrors);
      testsRun++;
      totalChecks += testChecks;
      totalErrors += testErrors;
   endtask

   function automatic int pendingCount();
      return expQ.size();
   endfunction

   ////////////////////////////////////////
   // Port monitor
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      logic [0:busWidth] expMem;
      if (!rstN)
      begin
         readPending = 1'b0;
         memCreditModel = memCredits;
      end
      else
      begin
         // Read data is due exactly one cycle after the strobe
         if (regRdValid && !readPending)
            reportFailure("regRdValid arrived without a regRead one cycle earlier");
         else if (!regRdValid && readPending)
            reportFailure("regRdValid missing one cycle after regRead");
         else if (regRdValid)
         begin
            testChecks++;
            if (regRdData !== readExp)
               mismatch("regRdData", readExp, regRdData);
         end
         // Read sees the entry as it was before a same-cycle write
         readPending = regRead;
         readExp = refReadData(shadow[regIndex]);
         if (regWrite)
            shadow[regIndex] = packEntry(regData);
         // Lookup sees a write in its own cycle
         if (devValid)
         begin
            expQ.push_back(refTranslate(devAddr, shadow[devAddr[vpnLsb:vpnMsb]]));
            testReqs++;
         end
         if (memValid)
         begin
            if (memCreditModel <= 0)
               reportFailure("memValid while no memory credit remained");
            if (expQ.size() == 0)
               reportFailure("unexpected memValid with no request outstanding");
            else
            begin
               expMem = expQ.pop_front();
               testChecks++;
               if (memAddr !== expMem[0:busWidth-1])
                  mismatch("memAddr", expMem[0:busWidth-1], memAddr);
               if (memFail !== expMem[busWidth])
               begin
                  $display("[ERROR] %s: memFail expected %b actual %b",
                           testName, expMem[busWidth], memFail);
                  testErrors++;
               end
            end
            memCreditModel--;
         end
         if (memCreditIn)
            memCreditModel++;
         if (devCredit)
            testCredits++;
      end
   end

endmodule

`default_nettype wire

// ==== dv/ubaPagerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ubaPagerTb
   import ubaPagePkg::*;
();

   localparam int devCredits = 4;
   localparam int memCredits = 2;
   localparam int holdCycles = 12;
   localparam int numTests   = 9;
   // Device requests from the valid page, fault, back-pressure and update tests
   localparam int totalReq   = 32 + (5 * 4) + devCredits + (2 * 4);
   localparam int timeoutLimit = 2 * totalReq * 8 + 200;

   logic                clk;
   logic                rstN;
   logic                regWrite;
   logic                regRead;
   logic [0:vpnWidth-1] regIndex;
   logic [0:busWidth-1] regData;
   logic                regRdValid;
   logic [0:busWidth-1] regRdData;
   logic                devValid;
   logic [0:busWidth-1] devAddr;
   logic                devCredit;
   logic                memValid;
   logic [0:busWidth-1] memAddr;
   logic                memFail;
   logic                memCreditIn = 1'b0;

   int   seed = 32'hf7c2;
   int   cycleCount = 0;
   int   sentCount = 0;
   int   returnedCount = 0;
   logic holdCredits = 1'b0;
   // Cycles at which a memory credit is due back
   int   dueQ [$];

   ubaPager #(
      .devCredits (devCredits),
      .memCredits (memCredits)
   ) i_ubaPager (
      .clk         (clk),
      .rstN        (rstN),
      .regWrite    (regWrite),
      .regRead     (regRead),
      .regIndex    (regIndex),
      .regData     (regData),
      .regRdValid  (regRdValid),
      .regRdData   (regRdData),
      .devValid    (devValid),
      .devAddr     (devAddr),
      .devCredit   (devCredit),
      .memValid    (memValid),
      .memAddr     (memAddr),
      .memFail     (memFail),
      .memCreditIn (memCreditIn)
   );

   ubaPagerChecker #(
      .memCredits (memCredits)
   ) i_ubaPagerChecker (
      .clk         (clk),
      .rstN        (rstN),
      .regWrite    (regWrite),
      .regRead     (regRead),
      .regIndex    (regIndex),
      .regData     (regData),
      .regRdValid  (regRdValid),
      .regRdData   (regRdData),
      .devValid    (devValid),
      .devAddr     (devAddr),
      .devCredit   (devCredit),
      .memValid    (memValid),
      .memAddr     (memAddr),
      .memFail     (memFail),
      .memCreditIn (memCreditIn)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // Cycle count, timeout, device credits
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (devCredit)
         returnedCount <= returnedCount + 1;
      if (cycleCount >= timeoutLimit)
      begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycleCount);
         $display("TEST FAIL");
         $finish;
      end
   end

   // Memory side returns each credit 0 to 5 cycles after memValid
   always @(negedge clk)
   begin
      int delay;
      int idx;
      memCreditIn = 1'b0;
      if (memValid)
      begin
         delay = {$random(seed)} % 6;
         dueQ.push_back(cycleCount + 1 + delay);
      end
      if (!holdCredits)
      begin
         idx = -1;
         for (int i = 0; i < dueQ.size(); i++)
            if ((idx < 0) && (dueQ[i] <= cycleCount))
               idx = i;
         if (idx >= 0)
         begin
            dueQ.delete(idx);
            memCreditIn = 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////

   task automatic randomBits(output logic [63:0] r);
      r = {$random(seed), $random(seed)};
   endtask

   // Random filler in the ignored bits with the fields in the write layout
   task automatic buildWord(input logic [0:ppnWidth-1] ppn, input logic [0:3] flags,
                            output logic [0:busWidth-1] data);
      logic [63:0] r;
      randomBits(r);
      data = r[35:0];
      data[wrFlagLsb:wrFlagLsb+3] = flags;
      data[wrPpnLsb:wrPpnMsb] = ppn;
   endtask

   task automatic makeAddr(input logic [0:vpnWidth-1] vpn, input logic a18,
                           input logic [0:1] low, output logic [0:busWidth-1] addr);
      logic [63:0] r;
      randomBits(r);
      addr = r[35:0];
      addr[addrA18] = a18;
      addr[vpnLsb:vpnMsb] = vpn;
      addr[addrWordSel] = low[0];
      addr[addrByteSel] = low[1];
   endtask

   task automatic writeEntry(input logic [0:vpnWidth-1] idx, input logic [0:busWidth-1] data);
      regWrite = 1'b1;
      regIndex = idx;
      regData = data;
      @(negedge clk);
      regWrite = 1'b0;
   endtask

   task automatic readEntry(input logic [0:vpnWidth-1] idx);
      regRead = 1'b1;
      regIndex = idx;
      @(negedge clk);
      regRead = 1'b0;
   endtask

   task automatic waitDevCredit();
      while ((sentCount - returnedCount) >= devCredits)
         @(negedge clk);
   endtask

   task automatic sendRequest(input logic [0:busWidth-1] addr);
      waitDevCredit();
      devValid = 1'b1;
      devAddr = addr;
      sentCount++;
      @(negedge clk);
      devValid = 1'b0;
   endtask

   // Table write and lookup in the same cycle
   task automatic writeAndSend(input logic [0:vpnWidth-1] idx, input logic [0:busWidth-1] data,
                               input logic [0:busWidth-1] addr);
      waitDevCredit();
      regWrite = 1'b1;
      regIndex = idx;
      regData = data;
      devValid = 1'b1;
      devAddr = addr;
      sentCount++;
      @(negedge clk);
      regWrite = 1'b0;
      devValid = 1'b0;
   endtask

   task automatic drain();
      while ((sentCount != returnedCount) || (i_ubaPagerChecker.pendingCount() != 0) ||
             (dueQ.size() != 0))
         @(negedge clk);
      repeat (2) @(negedge clk);
   endtask

   task automatic faultCase(input string name, input logic [0:3] flags, input logic a18,
                            input logic [0:1] low);
      logic [63:0]         r;
      logic [0:busWidth-1] data;
      logic [0:busWidth-1] addr;
      i_ubaPagerChecker.beginTest(name);
      randomBits(r);
      buildWord(r[16:6], flags, data);
      writeEntry(r[5:0], data);
      for (int k = 0; k < 4; k++)
      begin
         makeAddr(r[5:0], a18, low, addr);
         sendRequest(addr);
      end
      drain();
      i_ubaPagerChecker.endTest();
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      logic [63:0]         r;
      logic [0:busWidth-1] data;
      logic [0:busWidth-1] addr;
      rstN = 1'b0;
      regWrite = 1'b0;
      regRead = 1'b0;
      regIndex = '0;
      regData = '0;
      devValid = 1'b0;
      devAddr = '0;
      repeat (8) @(negedge clk);
      rstN = 1'b1;
      @(negedge clk);

      // Full random words exercise the ignored bits too
      i_ubaPagerChecker.beginTest("readBack");
      for (int i = 0; i < 64; i++)
      begin
         randomBits(r);
         writeEntry(i[vpnWidth-1:0], r[35:0]);
      end
      for (int i = 0; i < 64; i++)
         readEntry(i[vpnWidth-1:0]);
      drain();
      i_ubaPagerChecker.endTest();

      // Every page valid with FTM off
      i_ubaPagerChecker.beginTest("validPages");
      for (int i = 0; i < 64; i++)
      begin
         randomBits(r);
         buildWord(r[12:2], {r[0], r[1], 1'b0, 1'b1}, data);
         writeEntry(i[vpnWidth-1:0], data);
      end
      for (int i = 0; i < 32; i++)
      begin
         randomBits(r);
         makeAddr(r[5:0], 1'b0, r[7:6], addr);
         sendRequest(addr);
      end
      drain();
      i_ubaPagerChecker.endTest();

      // flags are RPW, E16, FTM, VLD
      faultCase("faultA18", 4'b0001, 1'b1, 2'b00);
      faultCase("faultInvalid", 4'b0000, 1'b0, 2'b00);
      faultCase("faultFtmBit34", 4'b0011, 1'b0, 2'b10);
      faultCase("faultFtmBit35", 4'b0011, 1'b0, 2'b01);
      faultCase("ftmAligned", 4'b0011, 1'b0, 2'b00);

      // Queue fills up to the device credit limit while memory credits are withheld
      i_ubaPagerChecker.beginTest("backPressure");
      holdCredits = 1'b1;
      randomBits(r);
      buildWord(r[16:6], 4'b0001, data);
      writeEntry(r[5:0], data);
      for (int k = 0; k < devCredits; k++)
      begin
         makeAddr(r[5:0], 1'b0, 2'b00, addr);
         sendRequest(addr);
      end
      repeat (holdCycles) @(negedge clk);
      holdCredits = 1'b0;
      drain();
      i_ubaPagerChecker.endTest();

      // Odd passes rewrite and look up in the same cycle
      i_ubaPagerChecker.beginTest("tableUpdate");
      for (int k = 0; k < 4; k++)
      begin
         randomBits(r);
         buildWord(r[16:6], 4'b0001, data);
         writeEntry(r[5:0], data);
         makeAddr(r[5:0], 1'b0, r[18:17], addr);
         sendRequest(addr);
         buildWord(r[29:19], {r[30], r[31], r[32], 1'b1}, data);
         makeAddr(r[5:0], 1'b0, r[34:33], addr);
         if (k % 2 == 1)
            writeAndSend(r[5:0], data, addr);
         else
         begin
            writeEntry(r[5:0], data);
            sendRequest(addr);
         end
      end
      drain();
      i_ubaPagerChecker.endTest();

      $display("Summary: %0d tests, %0d checks, %0d errors", i_ubaPagerChecker.testsRun,
               i_ubaPagerChecker.totalChecks, i_ubaPagerChecker.totalErrors);
      if ((i_ubaPagerChecker.totalErrors == 0) && (i_ubaPagerChecker.testsRun == numTests))
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/pageRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module pageRam
   import ubaPagePkg::*;
(
   input  logic                  clk,
   // Processor port
   input  logic                  entryWe,
   input  logic [0:vpnWidth-1]   entryIdx,
   input  logic [0:entryWidth-1] entryWr,
   output logic [0:entryWidth-1] entryRd,
   // Translate port
   input  logic [0:vpnWidth-1]   lookupVpn,
   output logic [0:entryWidth-1] lookupEntry
);

   // One entry per virtual page
   localparam int tableDepth = 1 << vpnWidth;

   logic [0:entryWidth-1] pageTable [0:tableDepth-1];

   ////////////////////////////////////////
   // Port A, processor read/write
   ////////////////////////////////////////

   // Read returns the old entry on a same-cycle write
   always_ff @(posedge clk)
   begin
      if (entryWe)
      begin
         pageTable[entryIdx] <= entryWr;
      end
      entryRd <= pageTable[entryIdx];
   end

   ////////////////////////////////////////
   // Port B, translate lookup
   ////////////////////////////////////////

   // Write-through bypass so a lookup in the write cycle sees the new entry
   always_ff @(posedge clk)
   begin
      if (entryWe && (entryIdx == lookupVpn))
      begin
         lookupEntry <= entryWr;
      end
      else
      begin
         lookupEntry <= pageTable[lookupVpn];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pageRegAccess.sv ====
`timescale 1ns/1ps
`default_nettype none

module pageRegAccess
   import ubaPagePkg::*;
(
   input  logic                  clk,
   input  logic                  rstN,
   // Processor register port
   input  logic                  regWrite,
   input  logic                  regRead,
   input  logic [0:vpnWidth-1]   regIndex,
   input  logic [0:busWidth-1]   regData,
   output logic                  regRdValid,
   output logic [0:busWidth-1]   regRdData,
   // Page table processor port
   output logic                  entryWe,
   output logic [0:vpnWidth-1]   entryIdx,
   output logic [0:entryWidth-1] entryWr,
   input  logic [0:entryWidth-1] entryRd
);

   ////////////////////////////////////////
   // Write path
   ////////////////////////////////////////

   // Same index serves both reads and writes
   assign entryWe  = regWrite;
   assign entryIdx = regIndex;

   // Flags from RH bits 18..21, PPN from RH bits 25..35
   // bits 22..24 and the whole LH are ignored
   always_comb
   begin
      entryWr                          = '0;
      entryWr[flagRpw]                 = regData[wrFlagLsb + flagRpw];
      entryWr[flagE16]                 = regData[wrFlagLsb + flagE16];
      entryWr[flagFtm]                 = regData[wrFlagLsb + flagFtm];
      entryWr[flagVld]                 = regData[wrFlagLsb + flagVld];
      entryWr[entryPpnLsb:entryPpnMsb] = regData[wrPpnLsb:wrPpnMsb];
   end

   ////////////////////////////////////////
   // Read path
   ////////////////////////////////////////

   // Table read is synchronous, so valid trails the strobe by one cycle
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         regRdValid <= 1'b0;
      end
      else
      begin
         regRdValid <= regRead;
      end
   end

   // Flags land on LH bits 5..8, PPN straddles the halves at 16..26
   always_comb
   begin
      regRdData                     = '0;
      regRdData[rdFlagLsb + flagRpw] = entryRd[flagRpw];
      regRdData[rdFlagLsb + flagE16] = entryRd[flagE16];
      regRdData[rdFlagLsb + flagFtm] = entryRd[flagFtm];
      regRdData[rdFlagLsb + flagVld] = entryRd[flagVld];
      regRdData[rdPpnLsb:rdPpnMsb]   = entryRd[entryPpnLsb:entryPpnMsb];
   end

endmodule

`default_nettype wire

// ==== verilog/pageTranslate.sv ====
`timescale 1ns/1ps
`default_nettype none

module pageTranslate
   import ubaPagePkg::*;
#(
   parameter int devCredits = 4,
   parameter int memCredits = 2
)
(
   input  logic                  clk,
   input  logic                  rstN,
   // Device side
   input  logic                  devValid,
   input  logic [0:busWidth-1]   devAddr,
   output logic                  devCredit,
   // Page table lookup
   output logic [0:vpnWidth-1]   lookupVpn,
   input  logic [0:entryWidth-1] lookupEntry,
   // Memory side
   output logic                  memValid,
   output logic [0:busWidth-1]   memAddr,
   output logic                  memFail,
   input  logic                  memCreditIn
);

   localparam int ptrWidth  = (devCredits > 1) ? $clog2(devCredits) : 1;
   localparam int cntWidth  = $clog2(devCredits + 1);
   localparam int credWidth = $clog2(memCredits + 1);

   ////////////////////////////////////////
   // Stage 1, lookup
   ////////////////////////////////////////

   logic                s1Valid;
   logic [0:busWidth-1] s1Addr;

   // Table is read on the same edge that captures the request
   assign lookupVpn = devAddr[vpnLsb:vpnMsb];

   always_ff @(posedge clk)
   begin
      if (!rstN)
         s1Valid <= 1'b0;
      else
         s1Valid <= devValid;
      s1Addr <= devAddr;
   end

   ////////////////////////////////////////
   // Stage 2, address and fault check
   ////////////////////////////////////////

   logic [0:ppnWidth-1]  s2Ppn;
   logic [0:wordWidth-1] s2Word;
   logic [0:busWidth-1]  s2Addr;
   logic                 s2Fail;

   assign s2Ppn  = lookupEntry[entryPpnLsb:entryPpnMsb];
   assign s2Word = s1Addr[wordLsb:wordMsb];
   // High flags, then physical page, then word
   assign s2Addr = {s1Addr[0:addrKeepMsb], s2Ppn, s2Word};

   // NXM on A18, on an invalid page, or on an unaligned FTM access
   assign s2Fail = s1Addr[addrA18] | ~lookupEntry[flagVld] |
                   (lookupEntry[flagFtm] & (s1Addr[addrWordSel] | s1Addr[addrByteSel]));

   ////////////////////////////////////////
   // Output queue and credits
   ////////////////////////////////////////

   logic [0:busWidth-1]  qAddr [0:devCredits-1];
   logic                 qFail [0:devCredits-1];
   logic [ptrWidth-1:0]  wrPtr;
   logic [ptrWidth-1:0]  rdPtr;
   logic [cntWidth-1:0]  qCount;
   logic [credWidth-1:0] memCredit;
   logic                 pop;

   // Device credits bound the queue, so push never sees it full
   always_ff @(posedge clk)
   begin
      if (s1Valid)
      begin
         qAddr[wrPtr] <= s2Addr;
         qFail[wrPtr] <= s2Fail;
      end
   end

   // Head goes out whenever memory can take it
   assign pop       = (qCount != '0) && (memCredit != '0);
   assign memValid  = pop;
   assign memAddr   = qAddr[rdPtr];
   assign memFail   = qFail[rdPtr];
   // Slot freed, device may send again
   assign devCredit = pop;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         wrPtr     <= '0;
         rdPtr     <= '0;
         qCount    <= '0;
         memCredit <= credWidth'(memCredits);
      end
      else
      begin
         if (s1Valid)
            wrPtr <= (wrPtr == ptrWidth'(devCredits - 1)) ? '0 : wrPtr + 1'b1;
         if (pop)
            rdPtr <= (rdPtr == ptrWidth'(devCredits - 1)) ? '0 : rdPtr + 1'b1;
         // Occupancy
         case ({s1Valid, pop})
            2'b10:   qCount <= qCount + 1'b1;
            2'b01:   qCount <= qCount - 1'b1;
            default: qCount <= qCount;
         endcase
         // Memory credit counter, a send and a return cancel out
         case ({pop, memCreditIn})
            2'b10:   memCredit <= memCredit - 1'b1;
            2'b01:   memCredit <= memCredit + 1'b1;
            default: memCredit <= memCredit;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/ubaPagePkg.sv ====
`default_nettype none

package ubaPagePkg;

   ////////////////////////////////////////
   // Field widths
   ////////////////////////////////////////

   // Processor bus word, numbered 0 (MSB) to 35 (LSB)
   localparam int busWidth   = 36;
   // Virtual page number, also sets the table depth
   localparam int vpnWidth   = 6;
   localparam int ppnWidth   = 11;
   localparam int wordWidth  = 9;
   localparam int numFlags   = 4;
   // Table entry holds the flags followed by the PPN
   localparam int entryWidth = numFlags + ppnWidth;

   ////////////////////////////////////////
   // Table entry layout
   ////////////////////////////////////////

   localparam int flagRpw     = 0;
   localparam int flagE16     = 1;
   localparam int flagFtm     = 2;
   localparam int flagVld     = 3;
   localparam int entryPpnLsb = numFlags;
   localparam int entryPpnMsb = entryWidth - 1;

   ////////////////////////////////////////
   // Device address and bus word positions
   ////////////////////////////////////////

   // High flag bits passed straight through to memory
   localparam int addrKeepMsb = 15;
   localparam int addrA18     = 18;
   localparam int vpnLsb      = 19;
   localparam int vpnMsb      = vpnLsb + vpnWidth - 1;
   localparam int wordLsb     = 25;
   localparam int wordMsb     = wordLsb + wordWidth - 1;
   // Word and byte select, the two low address bits
   localparam int addrWordSel = 34;
   localparam int addrByteSel = 35;

   // Write layout, right half only
   localparam int wrFlagLsb   = 18;
   localparam int wrPpnLsb    = 25;
   localparam int wrPpnMsb    = wrPpnLsb + ppnWidth - 1;

   // Read layout, everything else reads as zero
   localparam int rdFlagLsb   = 5;
   localparam int rdPpnLsb    = 16;
   localparam int rdPpnMsb    = rdPpnLsb + ppnWidth - 1;

endpackage

`default_nettype wire

// ==== verilog/ubaPager.sv ====
`timescale 1ns/1ps
`default_nettype none

module ubaPager
   import ubaPagePkg::*;
#(
   parameter int devCredits = 4,
   parameter int memCredits = 2
)
(
   input  logic                clk,
   input  logic                rstN,
   // Processor register port
   input  logic                regWrite,
   input  logic                regRead,
   input  logic [0:vpnWidth-1] regIndex,
   input  logic [0:busWidth-1] regData,
   output logic                regRdValid,
   output logic [0:busWidth-1] regRdData,
   // Device port
   input  logic                devValid,
   input  logic [0:busWidth-1] devAddr,
   output logic                devCredit,
   // Memory port
   output logic                memValid,
   output logic [0:busWidth-1] memAddr,
   output logic                memFail,
   input  logic                memCreditIn
);

   ////////////////////////////////////////
   // Internal nets
   ////////////////////////////////////////

   // Processor side of the table
   logic                  entryWe;
   logic [0:vpnWidth-1]   entryIdx;
   logic [0:entryWidth-1] entryWr;
   logic [0:entryWidth-1] entryRd;
   // Translate side of the table
   logic [0:vpnWidth-1]   lookupVpn;
   logic [0:entryWidth-1] lookupEntry;

   ////////////////////////////////////////
   // Register access
   ////////////////////////////////////////

   pageRegAccess i_pageRegAccess (
      .clk        (clk),
      .rstN       (rstN),
      .regWrite   (regWrite),
      .regRead    (regRead),
      .regIndex   (regIndex),
      .regData    (regData),
      .regRdValid (regRdValid),
      .regRdData  (regRdData),
      .entryWe    (entryWe),
      .entryIdx   (entryIdx),
      .entryWr    (entryWr),
      .entryRd    (entryRd)
   );

   // Dual port table, processor on A and translation on B
   pageRam i_pageRam (
      .clk         (clk),
      .entryWe     (entryWe),
      .entryIdx    (entryIdx),
      .entryWr     (entryWr),
      .entryRd     (entryRd),
      .lookupVpn   (lookupVpn),
      .lookupEntry (lookupEntry)
   );

   ////////////////////////////////////////
   // Translation
   ////////////////////////////////////////

   pageTranslate #(
      .devCredits (devCredits),
      .memCredits (memCredits)
   ) i_pageTranslate (
      .clk         (clk),
      .rstN        (rstN),
      .devValid    (devValid),
      .devAddr     (devAddr),
      .devCredit   (devCredit),
      .lookupVpn   (lookupVpn),
      .lookupEntry (lookupEntry),
      .memValid    (memValid),
      .memAddr     (memAddr),
      .memFail     (memFail),
      .memCreditIn (memCreditIn)
   );

endmodule

`default_nettype wire
